/* sources.f */
rtl/portalPkg.sv
rtl/beatIf.sv
rtl/burstSplitter.sv
rtl/portalRegs.sv
rtl/portalBridge.sv
dv/portalBridgeTb.sv

/* dv/portalBridgeTb.sv */
`timescale 1ns/1ns

module portalBridgeTb;

  localparam int CLK_PERIOD      = 4;
  localparam int TEST_COUNT      = 6;
  localparam int CYCLES_PER_TEST = 200;

  localparam int CTRL_PAGE    = 0;
  localparam int REQUEST_PAGE = 1;
  localparam int IND_PAGE     = 2;

  localparam logic [31:0] ID_WORD      = 32'd1;
  localparam logic [31:0] VERSION_WORD = 32'd2;
  localparam logic [31:0] KIND_REQ     = 32'd5;
  localparam logic [31:0] KIND_IND     = 32'd6;

  logic            CLK;
  logic            nRST;
  logic            arEna;
  logic [12:0]     arAddr;
  portalPkg::lenT  arLen;
  portalPkg::tagT  arTag;
  logic            arRdy;
  logic            rEna;
  portalPkg::dataT rData;
  portalPkg::tagT  rTag;
  logic            rLast;
  logic            rRdy;
  logic            awEna;
  logic [12:0]     awAddr;
  portalPkg::lenT  awLen;
  portalPkg::tagT  awTag;
  logic            awRdy;
  logic            wEna;
  portalPkg::dataT wData;
  logic            wRdy;
  logic            bEna;
  portalPkg::tagT  bTag;
  logic            bRdy;
  logic            irq;

  logic [15:0]     lfsrState = 16'd76;
  logic            stallMode = 1'b0;  // Random rRdy and bRdy
  string           curTest = "reset";

  portalPkg::dataT modelQ [$];
  logic            modelIntEn = 1'b0;

  portalPkg::dataT expRdData [$];
  portalPkg::tagT  expRdTag [$];
  logic            expRdLast [$];
  portalPkg::tagT  expBTag [$];

  portalPkg::dataT burstWords [16];  // Staging for the write driver
  portalPkg::dataT loopWords [3];
  portalPkg::dataT blockWords [4];
  portalPkg::dataT fullWords [5];

  portalBridge #(
    .QUEUE_DEPTH (4)
  ) i_dut (
    .CLK    (CLK),
    .nRST   (nRST),
    .arEna  (arEna),
    .arAddr (arAddr),
    .arLen  (arLen),
    .arTag  (arTag),
    .arRdy  (arRdy),
    .rEna   (rEna),
    .rData  (rData),
    .rTag   (rTag),
    .rLast  (rLast),
    .rRdy   (rRdy),
    .awEna  (awEna),
    .awAddr (awAddr),
    .awLen  (awLen),
    .awTag  (awTag),
    .awRdy  (awRdy),
    .wEna   (wEna),
    .wData  (wData),
    .wRdy   (wRdy),
    .bEna   (bEna),
    .bTag   (bTag),
    .bRdy   (bRdy),
    .irq    (irq)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      bits = {bits[30:0], lfsrState[0]};
    end
    return bits;
  endfunction

  function automatic int regionOf(input logic [12:0] busAddr);
    if (busAddr[11:5] == 7'd0) begin
      return CTRL_PAGE;
    end
    return busAddr[12] ? IND_PAGE : REQUEST_PAGE;
  endfunction

  // Expected read word that pops the model queue like the portal does
  function automatic logic [31:0] expectedRead(input logic [12:0] busAddr, input logic [4:0] off);
    logic [31:0] word;
    word = '0;
    case (regionOf(busAddr))
      CTRL_PAGE: begin
        case (off)
          5'h00, 5'h0C: word = {31'd0, modelQ.size() != 0};
          5'h08:        word = ID_WORD;
          5'h10:        word = busAddr[12] ? KIND_IND : KIND_REQ;
          5'h14:        word = VERSION_WORD;
          default:      word = '0;
        endcase
      end
      IND_PAGE: begin
        if (off == 5'h00 && modelQ.size() != 0) begin
          word = modelQ.pop_front();
        end else if (off == 5'h04) begin
          word = modelQ.size();
        end
      end
      default: word = '0;
    endcase
    return word;
  endfunction

  function automatic logic [31:0] expectedIrq();
    return {31'd0, modelIntEn && (modelQ.size() != 0)};
  endfunction

  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      reportFailure($sformatf("FAIL %s %s: expected 0x%08h actual 0x%08h",
                              curTest, what, expected, actual));
    end
  endtask

  task automatic readBurst(input logic [12:0] addr, input portalPkg::lenT len,
                           input portalPkg::tagT tag);
    logic [4:0] off;
    int k;
    for (k = 0; k <= int'(len); k++) begin
      off = addr[4:0] + 5'(4 * k);  // Wraps inside the page
      expRdData.push_back(expectedRead(addr, off));
      expRdTag.push_back(tag);
      expRdLast.push_back(k == int'(len));
    end
    @(posedge CLK);
    arEna  <= 1'b1;
    arAddr <= addr;
    arLen  <= len;
    arTag  <= tag;
    @(posedge CLK);
    while (!arRdy) begin
      @(posedge CLK);
    end
    arEna <= 1'b0;
  endtask

  task automatic writeBurst(input logic [12:0] addr, input portalPkg::lenT len,
                            input portalPkg::tagT tag);
    logic [4:0] off;
    int region;
    int k;
    int j;
    region = regionOf(addr);
    for (k = 0; k <= int'(len); k++) begin
      off = addr[4:0] + 5'(4 * k);
      if (region == REQUEST_PAGE && off == 5'h00) begin
        modelQ.push_back(burstWords[k]);
      end else if (region == CTRL_PAGE && off == 5'h04) begin
        modelIntEn = burstWords[k][0];
      end
    end
    expBTag.push_back(tag);
    @(posedge CLK);
    fork
      begin
        awEna  <= 1'b1;
        awAddr <= addr;
        awLen  <= len;
        awTag  <= tag;
        @(posedge CLK);
        while (!awRdy) begin
          @(posedge CLK);
        end
        awEna <= 1'b0;
      end
      begin
        for (j = 0; j <= int'(len); j++) begin
          wEna  <= 1'b1;
          wData <= burstWords[j];
          @(posedge CLK);
          while (!wRdy) begin
            @(posedge CLK);
          end
        end
        wEna <= 1'b0;
      end
    join
  endtask

  task automatic waitIdle();
    @(negedge CLK);
    while (expRdData.size() != 0 || expBTag.size() != 0) begin
      @(negedge CLK);
    end
  endtask

  task automatic runLoopback(input portalPkg::tagT tagBase);
    int i;
    for (i = 0; i < 3; i++) begin
      burstWords[0] = loopWords[i];
      writeBurst(13'h0020, 4'd0, tagBase + 6'(i));
      waitIdle();
    end
    readBurst(13'h1024, 4'd0, tagBase + 6'd3);  // Fill level
    for (i = 0; i < 4; i++) begin
      readBurst(13'h1020, 4'd0, tagBase + 6'(4 + i));  // Last one finds it empty
    end
    waitIdle();
  endtask

  task automatic runBlockWrite(input portalPkg::tagT tagBase);
    int i;
    for (i = 0; i < 4; i++) begin
      burstWords[i] = blockWords[i];
    end
    writeBurst(13'h0020, 4'd3, tagBase);  // Only offset 0 pushes
    waitIdle();
    readBurst(13'h1024, 4'd0, tagBase + 6'd1);
    readBurst(13'h1020, 4'd0, tagBase + 6'd2);
    waitIdle();
  endtask

  // Read data and write response checker
  always @(posedge CLK) begin
    if (nRST && rEna && rRdy) begin
      if (expRdData.size() == 0) begin
        reportFailure($sformatf("Read data came back with no read outstanding in %s", curTest));
      end else begin
        checkValue("rData", expRdData.pop_front(), rData);
        checkValue("rTag", expRdTag.pop_front(), rTag);
        checkValue("rLast", expRdLast.pop_front(), rLast);
      end
    end
    if (nRST && bEna && bRdy) begin
      if (expBTag.size() == 0) begin
        reportFailure($sformatf("Extra write response in %s", curTest));
      end else begin
        checkValue("bTag", expBTag.pop_front(), bTag);
      end
    end
  end

  initial begin
    rRdy = 1'b1;
    bRdy = 1'b1;
    forever begin
      @(posedge CLK);
      if (stallMode) begin
        rRdy <= takeBits(1) != 0;
        bRdy <= takeBits(1) != 0;
      end else begin
        rRdy <= 1'b1;
        bRdy <= 1'b1;
      end
    end
  end

  initial begin
    #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
    reportFailure($sformatf("Watchdog expired during %s, the run hung", curTest));
  end

  initial begin
    int i;
    nRST   <= 1'b0;
    arEna  <= 1'b0;
    arAddr <= '0;
    arLen  <= '0;
    arTag  <= '0;
    awEna  <= 1'b0;
    awAddr <= '0;
    awLen  <= '0;
    awTag  <= '0;
    wEna   <= 1'b0;
    wData  <= '0;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    checkValue("arRdy", 32'd1, arRdy);
    checkValue("awRdy", 32'd1, awRdy);
    checkValue("rEna", 32'd0, rEna);
    checkValue("bEna", 32'd0, bEna);
    checkValue("irq", 32'd0, irq);

    curTest = "identity";
    readBurst(13'h0000, 4'd5, 6'h11);
    readBurst(13'h1010, 4'd0, 6'h12);  // Select bit set
    waitIdle();

    curTest = "loopback";
    for (i = 0; i < 3; i++) begin
      loopWords[i] = takeBits(32);
    end
    runLoopback(6'h20);

    curTest = "writeBurst";
    for (i = 0; i < 4; i++) begin
      blockWords[i] = takeBits(32);
    end
    runBlockWrite(6'h30);

    curTest = "interrupt";
    burstWords[0] = takeBits(32);
    writeBurst(13'h0020, 4'd0, 6'h38);
    waitIdle();
    checkValue("irq with enable off", expectedIrq(), irq);
    burstWords[0] = 32'd1;
    writeBurst(13'h0004, 4'd0, 6'h39);
    waitIdle();
    checkValue("irq with enable on", expectedIrq(), irq);
    readBurst(13'h1020, 4'd0, 6'h3A);
    waitIdle();
    checkValue("irq after drain", expectedIrq(), irq);

    curTest = "backPressure";
    for (i = 0; i < 3; i++) begin
      loopWords[i] = takeBits(32);
    end
    for (i = 0; i < 4; i++) begin
      blockWords[i] = takeBits(32);
    end
    stallMode <= 1'b1;  // No data draws from here on
    readBurst(13'h0000, 4'd5, 6'h0A);
    waitIdle();  // Status words sampled before the queue fills
    runLoopback(6'h10);
    runBlockWrite(6'h18);
    stallMode <= 1'b0;

    curTest = "fullQueue";
    for (i = 0; i < 5; i++) begin
      fullWords[i] = takeBits(32);
    end
    for (i = 0; i < 4; i++) begin
      burstWords[0] = fullWords[i];
      writeBurst(13'h0020, 4'd0, 6'h01 + 6'(i));
      waitIdle();
    end
    burstWords[0] = fullWords[4];
    fork
      writeBurst(13'h0020, 4'd0, 6'h05);
      begin
        repeat (12) @(negedge CLK);
        checkValue("awRdy and wRdy while full", 32'd0, {awRdy, wRdy});
        checkValue("responses pending while full", 32'd1, expBTag.size());
        readBurst(13'h1020, 4'd0, 6'h06);  // Frees one slot
      end
    join
    waitIdle();
    readBurst(13'h1024, 4'd0, 6'h07);
    for (i = 0; i < 4; i++) begin
      readBurst(13'h1020, 4'd0, 6'h08 + 6'(i));
    end
    waitIdle();

    repeat (20) @(posedge CLK);  // Catch late extra transfers
    $display("All checks passed");
    $finish;
  end

endmodule

/* rtl/portalBridge.sv */
`timescale 1ns/1ns

module portalBridge #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            CLK,
  input  logic            nRST,

  input  logic            arEna,
  input  logic [12:0]     arAddr,
  input  portalPkg::lenT  arLen,
  input  portalPkg::tagT  arTag,
  output logic            arRdy,

  output logic            rEna,
  output portalPkg::dataT rData,
  output portalPkg::tagT  rTag,
  output logic            rLast,
  input  logic            rRdy,

  input  logic            awEna,
  input  logic [12:0]     awAddr,
  input  portalPkg::lenT  awLen,
  input  portalPkg::tagT  awTag,
  output logic            awRdy,

  input  logic            wEna,
  input  portalPkg::dataT wData,
  output logic            wRdy,

  output logic            bEna,
  output portalPkg::tagT  bTag,
  input  logic            bRdy,

  output logic            irq
);

  beatIf rdBeat ();
  beatIf wrBeat ();

  burstSplitter rdSplit (
    .CLK     (CLK),
    .nRST    (nRST),
    .reqEna  (arEna),
    .reqAddr (arAddr),
    .reqLen  (arLen),
    .reqTag  (arTag),
    .reqRdy  (arRdy),
    .beat    (rdBeat.source)
  );

  burstSplitter wrSplit (
    .CLK     (CLK),
    .nRST    (nRST),
    .reqEna  (awEna),
    .reqAddr (awAddr),
    .reqLen  (awLen),
    .reqTag  (awTag),
    .reqRdy  (awRdy),
    .beat    (wrBeat.source)
  );

  // Shared queue and control page for both directions
  portalRegs #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) regs (
    .CLK    (CLK),
    .nRST   (nRST),
    .rdBeat (rdBeat.sink),
    .wrBeat (wrBeat.sink),
    .wEna   (wEna),
    .wData  (wData),
    .wRdy   (wRdy),
    .rEna   (rEna),
    .rData  (rData),
    .rTag   (rTag),
    .rLast  (rLast),
    .rRdy   (rRdy),
    .bEna   (bEna),
    .bTag   (bTag),
    .bRdy   (bRdy),
    .irq    (irq)
  );

endmodule

/* rtl/portalRegs.sv */
`timescale 1ns/1ns

module portalRegs #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            CLK,
  input  logic            nRST,
  beatIf.sink             rdBeat,
  beatIf.sink             wrBeat,
  input  logic            wEna,
  input  portalPkg::dataT wData,
  output logic            wRdy,
  output logic            rEna,
  output portalPkg::dataT rData,
  output portalPkg::tagT  rTag,
  output logic            rLast,
  input  logic            rRdy,
  output logic            bEna,
  output portalPkg::tagT  bTag,
  input  logic            bRdy,
  output logic            irq
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  portalPkg::dataT  queueMem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             notEmpty;
  logic             full;
  logic             intEn;

  logic             rdTake;
  logic             pop;
  portalPkg::dataT  rdWord;

  logic             pushHit;
  logic             wrTake;
  logic             push;

  assign notEmpty = (count != '0);
  assign full     = (count == CNT_W'(QUEUE_DEPTH));
  assign irq      = intEn && notEmpty;

  // Read side
  assign rdBeat.rdy = !rEna || rRdy;
  assign rdTake     = rdBeat.ena && rdBeat.rdy;
  assign pop        = rdTake && notEmpty && (rdBeat.region == portalPkg::indicationRegion)
                      && (rdBeat.addr == 5'h00);

  always_comb begin
    rdWord = '0;
    case (rdBeat.region)
      portalPkg::ctrlRegion: begin
        case (rdBeat.addr)
          5'h00, 5'h0C: rdWord = {31'd0, notEmpty};
          5'h08:        rdWord = portalPkg::ID_WORD;
          5'h10:        rdWord = rdBeat.sel ? portalPkg::PORTAL_KIND_IND
                                            : portalPkg::PORTAL_KIND_REQ;
          5'h14:        rdWord = portalPkg::VERSION_WORD;
          default:      rdWord = '0;
        endcase
      end
      portalPkg::indicationRegion: begin
        if (rdBeat.addr == 5'h00) begin
          rdWord = notEmpty ? queueMem[rdPtr] : '0;
        end else if (rdBeat.addr == 5'h04) begin
          rdWord = {{(32 - CNT_W){1'b0}}, count};  // Fill level
        end
      end
      default: rdWord = '0;
    endcase
  end

  // Write beat and data word go together
  assign pushHit    = (wrBeat.region == portalPkg::requestRegion) && (wrBeat.addr == 5'h00);
  assign wrTake     = wrBeat.ena && wEna
                      && (!wrBeat.last || !bEna || bRdy)
                      && !(pushHit && full);  // Full queue stalls the channel
  assign wRdy       = wrTake;
  assign wrBeat.rdy = wrTake;
  assign push       = wrTake && pushHit;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      rEna  <= 1'b0;
      bEna  <= 1'b0;
      intEn <= 1'b0;
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (rdTake) begin
        rEna <= 1'b1;
      end else if (rRdy) begin
        rEna <= 1'b0;
      end
      if (wrTake && wrBeat.last) begin
        bEna <= 1'b1;
      end else if (bRdy) begin
        bEna <= 1'b0;
      end
      if (wrTake && (wrBeat.region == portalPkg::ctrlRegion) && (wrBeat.addr == 5'h04)) begin
        intEn <= wData[0];
      end
      if (push) begin
        wrPtr <= (wrPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge CLK) begin
    if (rdTake) begin
      rData <= rdWord;
      rTag  <= rdBeat.tag;
      rLast <= rdBeat.last;
    end
    if (wrTake && wrBeat.last) begin
      bTag <= wrBeat.tag;
    end
    if (push) begin
      queueMem[wrPtr] <= wData;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    count <= CNT_W'(QUEUE_DEPTH));

  // Write data stays put while the channel stalls
  assert property (@(posedge CLK) disable iff (!nRST)
    wEna && !wRdy |=> wEna && $stable(wData));

endmodule

/* rtl/burstSplitter.sv */
`timescale 1ns/1ns

module burstSplitter (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              reqEna,
  input  logic [12:0]       reqAddr,
  input  portalPkg::lenT    reqLen,
  input  portalPkg::tagT    reqTag,
  output logic              reqRdy,
  beatIf.source             beat
);

  portalPkg::splitStateT state;

  portalPkg::addrT   curAddr;
  portalPkg::lenT    remain;   // Beats left after the current one
  portalPkg::tagT    curTag;
  portalPkg::regionT curRegion;
  logic              curSel;

  logic reqTake;
  logic beatTake;

  assign reqRdy   = (state == portalPkg::idle);
  assign reqTake  = reqEna && reqRdy;
  assign beatTake = beat.ena && beat.rdy;

  assign beat.ena    = (state == portalPkg::busy);
  assign beat.addr   = curAddr;
  assign beat.tag    = curTag;
  assign beat.last   = (remain == '0);
  assign beat.region = curRegion;
  assign beat.sel    = curSel;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      state <= portalPkg::idle;
    end else begin
      case (state)
        portalPkg::idle: begin
          if (reqTake) begin
            state <= portalPkg::busy;
          end
        end
        portalPkg::busy: begin
          if (beatTake && beat.last) begin
            state <= portalPkg::idle;  // Ready again next cycle
          end
        end
        default: state <= portalPkg::idle;
      endcase
    end
  end

  // Burst context latched once per request
  always_ff @(posedge CLK) begin
    if (reqTake) begin
      curAddr   <= reqAddr[4:0];
      remain    <= reqLen;
      curTag    <= reqTag;
      curRegion <= portalPkg::decodeRegion(reqAddr);
      curSel    <= reqAddr[12];
    end else if (beatTake) begin
      curAddr <= curAddr + 5'd4;  // Wraps inside the page
      remain  <= remain - 1'b1;
    end
  end

  // A beat stream only starts right after a request was taken
  assert property (@(posedge CLK) disable iff (!nRST)
    $rose(beat.ena) |-> $past(reqTake));

  // Master holds a waiting request
  assert property (@(posedge CLK) disable iff (!nRST)
    reqEna && !reqRdy |=> reqEna && $stable(reqAddr) && $stable(reqLen) && $stable(reqTag));

endmodule

/* rtl/beatIf.sv */
`timescale 1ns/1ns

interface beatIf;

  logic              ena;
  logic              rdy;
  portalPkg::addrT   addr;
  portalPkg::tagT    tag;
  logic              last;
  portalPkg::regionT region;
  logic              sel;     // Bus address bit 12

  modport source (
    output ena, addr, tag, last, region, sel,
    input  rdy
  );

  modport sink (
    input  ena, addr, tag, last, region, sel,
    output rdy
  );

endinterface

/* rtl/portalPkg.sv */
package portalPkg;

  typedef logic [4:0]  addrT;  // Byte offset inside a page
  typedef logic [5:0]  tagT;
  typedef logic [3:0]  lenT;   // Beats minus one
  typedef logic [31:0] dataT;

  typedef enum logic [1:0] {
    ctrlRegion,
    requestRegion,
    indicationRegion
  } regionT;

  typedef enum logic {
    idle,
    busy
  } splitStateT;

  localparam dataT ID_WORD          = 32'd1;
  localparam dataT VERSION_WORD     = 32'd2;
  localparam dataT PORTAL_KIND_REQ  = 32'd5;
  localparam dataT PORTAL_KIND_IND  = 32'd6;

  // Page decode on a 13-bit bus address
  function automatic regionT decodeRegion(input logic [12:0] busAddr);
    regionT region;
    if (busAddr[11:5] == 7'd0) begin
      region = ctrlRegion;
    end else if (!busAddr[12]) begin
      region = requestRegion;
    end else begin
      region = indicationRegion;
    end
    return region;
  endfunction

endpackage
